/* video.f */
video_pkg.sv
video_ports.sv
video_sync.sv
video_tsline.sv
video_render.sv
video_palette.sv
video_top.sv
video_tb.sv

/* video_tb.sv */
// self-checking testbench for the video pipeline with a stimulus table and a cycle model
// top module video_tb is compiled from video.f with the small raster geometry
`timescale 1ns/1ps
`default_nettype none

module video_tb;

  import video_pkg::*;

  // small raster so a frame is 640 cycles
  localparam int H_T = 40;
  localparam int V_T = 16;
  localparam int HB = 8;
  localparam int HE = 32;
  localparam int VB = 4;
  localparam int VE = 12;
  localparam int CLK_PERIOD = 8;
  localparam int NROWS = 18;

  logic clk;
  logic arst_n;
  pix_t d;
  logic border_wr, vconf_wr, palsel_wr, hint_beg_wr, vint_begl_wr, vint_begh_wr;
  pix_t cram_addr;
  cram_data_t cram_data;
  logic cram_we;
  lbuf_addr_t ts_waddr;
  pix_t ts_wdata;
  logic ts_we;
  nib_t gfx_pix;
  hcnt_t hcnt;
  vcnt_t vcnt;
  logic hsync, vsync, line_start, int_start;
  chan_t red, green, blue;

  // stimulus rows {kind, addr, data, frame, h, v}
  logic [47:0] tbl [0:NROWS-1];
  logic table_ready = 1'b0;
  integer seed = 68;
  int errors = 0;
  logic gfx_rand;
  nib_t gfx_fixed;

  // reference model state
  hcnt_t hm;
  vcnt_t vm;
  int fm;
  pix_t border_m;
  pix_t hint_m;
  vcnt_t vint_m;
  nib_t bank_m;
  logic nogfx_m;
  logic notsu_m;
  rgb_t cram_m [0:255];
  pix_t lb_m [0:1][0:511];
  pix_t idx_d1;
  pix_t idx_d2;
  logic blank_d1;
  logic blank_d2;
  rgb_t exp_rgb;
  logic exp_hs, exp_vs, exp_ls, exp_int;
  logic sync_ok;

  video_top #(
    .H_TOTAL  (H_T),
    .V_TOTAL  (V_T),
    .HPIX_BEG (HB),
    .HPIX_END (HE),
    .VPIX_BEG (VB),
    .VPIX_END (VE)
  ) DUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .d            (d),
    .border_wr    (border_wr),
    .vconf_wr     (vconf_wr),
    .palsel_wr    (palsel_wr),
    .hint_beg_wr  (hint_beg_wr),
    .vint_begl_wr (vint_begl_wr),
    .vint_begh_wr (vint_begh_wr),
    .cram_addr    (cram_addr),
    .cram_data    (cram_data),
    .cram_we      (cram_we),
    .ts_waddr     (ts_waddr),
    .ts_wdata     (ts_wdata),
    .ts_we        (ts_we),
    .gfx_pix      (gfx_pix),
    .hcnt         (hcnt),
    .vcnt         (vcnt),
    .hsync        (hsync),
    .vsync        (vsync),
    .line_start   (line_start),
    .int_start    (int_start),
    .red          (red),
    .green        (green),
    .blue         (blue)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] got);
    assert (got === exp) else begin
      errors++;
      $display("Fail %0d ns: %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  // row kind 0 config port, 1 cram, 2 overlay pixel, 3 gfx source
  // config addr 0 border, 1 vconf, 2 palsel, 3 hint, 4 vint low, 5 vint high
  task automatic load_table();
    tbl[0]  = {2'd0, 8'd0,  16'h0021, 4'd1, 9'd0,  9'd0};
    tbl[1]  = {2'd0, 8'd2,  16'h0005, 4'd1, 9'd1,  9'd0};
    tbl[2]  = {2'd0, 8'd3,  16'd20,   4'd1, 9'd2,  9'd0};
    tbl[3]  = {2'd0, 8'd4,  16'd6,    4'd1, 9'd3,  9'd0};
    tbl[4]  = {2'd0, 8'd5,  16'h0000, 4'd1, 9'd4,  9'd0};
    tbl[5]  = {2'd3, 8'd0,  16'h0100, 4'd1, 9'd5,  9'd0};
    tbl[6]  = {2'd2, 8'd3,  16'h004a, 4'd1, 9'd10, 9'd5};
    // low nibble zero is transparent
    tbl[7]  = {2'd2, 8'd7,  16'h0030, 4'd1, 9'd12, 9'd5};
    // border colour rewritten mid frame
    tbl[8]  = {2'd1, 8'h21, 16'h7c1f, 4'd1, 9'd20, 9'd8};
    tbl[9]  = {2'd1, 8'h57, 16'h9234, 4'd1, 9'd0,  9'd9};
    tbl[10] = {2'd2, 8'd5,  16'h009c, 4'd2, 9'd20, 9'd6};
    tbl[11] = {2'd3, 8'd0,  16'h0007, 4'd2, 9'd0,  9'd7};
    // notsu on hides the next overlay pixel
    tbl[12] = {2'd0, 8'd1,  16'h0010, 4'd2, 9'd0,  9'd8};
    tbl[13] = {2'd2, 8'd2,  16'h0055, 4'd2, 9'd30, 9'd8};
    // nogfx on and notsu off
    tbl[14] = {2'd0, 8'd1,  16'h0020, 4'd3, 9'd0,  9'd1};
    tbl[15] = {2'd2, 8'd4,  16'h0061, 4'd3, 9'd35, 9'd9};
    // line 262 is never reached so no interrupt follows
    tbl[16] = {2'd0, 8'd5,  16'h0001, 4'd3, 9'd0,  9'd12};
    tbl[17] = {2'd3, 8'd0,  16'h0100, 4'd4, 9'd0,  9'd12};
  endtask

  task automatic idle_inputs();
    border_wr    <= 1'b0;
    vconf_wr     <= 1'b0;
    palsel_wr    <= 1'b0;
    hint_beg_wr  <= 1'b0;
    vint_begl_wr <= 1'b0;
    vint_begh_wr <= 1'b0;
    cram_we      <= 1'b0;
    ts_we        <= 1'b0;
  endtask

  // wait for the raster point then drive the row for one cycle
  task automatic run_row(input logic [47:0] row);
    logic [1:0] kind;
    logic [7:0] addr;
    logic [15:0] data;
    kind = row[47:46];
    addr = row[45:38];
    data = row[37:22];
    do begin
      @(posedge clk);
      idle_inputs();
    end while (!(fm == int'(row[21:18]) && hm == row[17:9] && vm == row[8:0]));
    case (kind)
      2'd0: begin
        d <= data[7:0];
        case (addr)
          8'd0: border_wr <= 1'b1;
          8'd1: vconf_wr <= 1'b1;
          8'd2: palsel_wr <= 1'b1;
          8'd3: hint_beg_wr <= 1'b1;
          8'd4: vint_begl_wr <= 1'b1;
          default: vint_begh_wr <= 1'b1;
        endcase
      end
      2'd1: begin
        cram_addr <= addr;
        cram_data <= data;
        cram_we   <= 1'b1;
      end
      2'd2: begin
        ts_waddr <= {1'b0, addr};
        ts_wdata <= data[7:0];
        ts_we    <= 1'b1;
      end
      default: begin
        gfx_rand  <= data[8];
        gfx_fixed <= data[3:0];
      end
    endcase
  endtask

  // graphics nibble is random or held
  always @(posedge clk) begin
    if (gfx_rand)
      gfx_pix <= nib_t'($random(seed));
    else
      gfx_pix <= gfx_fixed;
  end

  // model steps mid cycle when inputs and outputs are settled
  always @(negedge clk) begin : model
    logic [8:0] ra;
    logic win;
    pix_t ovl;
    pix_t idx;
    int i;
    if (!arst_n) begin
      hm = '0;
      vm = '0;
      fm = 0;
      border_m = '0;
      hint_m = '0;
      vint_m = '0;
      bank_m = '0;
      nogfx_m = 1'b0;
      notsu_m = 1'b0;
      blank_d1 = 1'b1;
      blank_d2 = 1'b1;
      sync_ok = 1'b0;
      for (i = 0; i < 512; i++) begin
        lb_m[0][i] = '0;
        lb_m[1][i] = '0;
      end
    end else begin
      check_val("hcnt", hm, hcnt);
      check_val("vcnt", vm, vcnt);
      if (sync_ok) begin
        check_val("hsync", exp_hs, hsync);
        check_val("vsync", exp_vs, vsync);
        check_val("line_start", exp_ls, line_start);
        check_val("int_start", exp_int, int_start);
      end
      // first frame holds unknown buffer and palette contents
      if (fm >= 1) begin
        check_val("red", exp_rgb[14:10], red);
        check_val("green", exp_rgb[9:5], green);
        check_val("blue", exp_rgb[4:0], blue);
      end
      // index of the pixel shown by the counters now
      win = (hm >= HB) && (hm < HE) && (vm >= VB) && (vm < VE);
      ra = hm - 9'(HB);
      ovl = lb_m[vm[0]][ra];
      if (!win)
        idx = border_m;
      else if (!notsu_m && ovl[3:0] != 4'h0)
        idx = ovl;
      else if (nogfx_m)
        idx = border_m;
      else
        idx = {bank_m, gfx_pix};
      // palette lookup two cycles on and output one more
      exp_rgb = blank_d2 ? '0 : cram_m[idx_d2];
      idx_d2 = idx_d1;
      blank_d2 = blank_d1;
      idx_d1 = idx;
      blank_d1 = (hm < HSYNC_LEN) || (vm < VSYNC_LEN);
      exp_hs = (hm < HSYNC_LEN);
      exp_vs = (vm < VSYNC_LEN);
      exp_ls = (hm == 0);
      exp_int = (hm == {1'b0, hint_m}) && (vm == vint_m);
      sync_ok = 1'b1;
      // writes of this cycle are seen from the next
      if (border_wr)
        border_m = d;
      if (palsel_wr)
        bank_m = d[3:0];
      if (hint_beg_wr)
        hint_m = d;
      if (vint_begl_wr)
        vint_m[7:0] = d;
      if (vint_begh_wr)
        vint_m[8] = d[0];
      if (vconf_wr) begin
        nogfx_m = d[VCONF_NOGFX];
        notsu_m = d[VCONF_NOTSU];
      end
      if (cram_we)
        cram_m[cram_addr] = cram_data[14:0];
      // shown once then cleared
      if (win)
        lb_m[vm[0]][ra] = '0;
      // writer fills the other line's buffer
      if (ts_we)
        lb_m[~vm[0]][ts_waddr] = ts_wdata;
      if (hm == H_T - 1) begin
        hm = '0;
        if (vm == V_T - 1) begin
          vm = '0;
          fm++;
        end else begin
          vm = vm + 1'b1;
        end
      end else begin
        hm = hm + 1'b1;
      end
    end
  end

  // run limit is twice the frames the table spans
  initial begin : watchdog
    int nfr;
    wait (table_ready);
    nfr = int'(tbl[NROWS-1][21:18]) + 2;
    #(2 * nfr * H_T * V_T * CLK_PERIOD);
    $display("timeout: run did not complete within the expected number of frames");
    $display("** FAIL **");
    $finish;
  end

  initial begin : main
    int r;
    int a;
    arst_n = 1'b0;
    d = '0;
    border_wr = 1'b0;
    vconf_wr = 1'b0;
    palsel_wr = 1'b0;
    hint_beg_wr = 1'b0;
    vint_begl_wr = 1'b0;
    vint_begh_wr = 1'b0;
    cram_addr = '0;
    cram_data = '0;
    cram_we = 1'b0;
    ts_waddr = '0;
    ts_wdata = '0;
    ts_we = 1'b0;
    gfx_pix = '0;
    gfx_rand = 1'b0;
    gfx_fixed = '0;
    load_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    // random palette with bit 15 included
    for (a = 0; a < 256; a++) begin
      @(posedge clk);
      cram_addr <= pix_t'(a);
      cram_data <= cram_data_t'($random(seed));
      cram_we   <= 1'b1;
    end
    for (r = 0; r < NROWS; r++)
      run_row(tbl[r]);
    @(posedge clk);
    idle_inputs();
    // one more frame so the last changes are seen
    repeat (H_T * V_T) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* video_top.sv */
// video pipeline top, configuration block beside raster, overlay, mux and palette
// geometry parameters are set here and passed to the raster counter
`timescale 1ns/1ps
`default_nettype none

module video_top #(
  parameter int H_TOTAL  = 448,
  parameter int V_TOTAL  = 320,
  parameter int HPIX_BEG = 64,
  parameter int HPIX_END = 320,
  parameter int VPIX_BEG = 40,
  parameter int VPIX_END = 232
) (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire  video_pkg::pix_t       d,
  input  wire                         border_wr,
  input  wire                         vconf_wr,
  input  wire                         palsel_wr,
  input  wire                         hint_beg_wr,
  input  wire                         vint_begl_wr,
  input  wire                         vint_begh_wr,
  input  wire  video_pkg::pix_t       cram_addr,
  input  wire  video_pkg::cram_data_t cram_data,
  input  wire                         cram_we,
  input  wire  video_pkg::lbuf_addr_t ts_waddr,
  input  wire  video_pkg::pix_t       ts_wdata,
  input  wire                         ts_we,
  input  wire  video_pkg::nib_t       gfx_pix,
  output video_pkg::hcnt_t            hcnt,
  output video_pkg::vcnt_t            vcnt,
  output logic                        hsync,
  output logic                        vsync,
  output logic                        line_start,
  output logic                        int_start,
  output video_pkg::chan_t            red,
  output video_pkg::chan_t            green,
  output video_pkg::chan_t            blue
);

  import video_pkg::*;

  // config
  pix_t  border;
  pix_t  hint_beg;
  vcnt_t vint_beg;
  nib_t  palsel_bank;
  logic  nogfx;
  logic  notsu;

  // raster to pipeline
  lbuf_addr_t lbuf_raddr;
  logic       line_odd;
  logic       win_now;
  logic       in_win;
  logic       sync_blank;

  // pixel path
  pix_t ts_pix;
  pix_t vplex;
  logic blank;

  video_ports u_ports (
    .clk          (clk),
    .arst_n       (arst_n),
    .d            (d),
    .border_wr    (border_wr),
    .vconf_wr     (vconf_wr),
    .palsel_wr    (palsel_wr),
    .hint_beg_wr  (hint_beg_wr),
    .vint_begl_wr (vint_begl_wr),
    .vint_begh_wr (vint_begh_wr),
    .border       (border),
    .nogfx        (nogfx),
    .notsu        (notsu),
    .palsel_bank  (palsel_bank),
    .hint_beg     (hint_beg),
    .vint_beg     (vint_beg)
  );

  video_sync #(
    .H_TOTAL  (H_TOTAL),
    .V_TOTAL  (V_TOTAL),
    .HPIX_BEG (HPIX_BEG),
    .HPIX_END (HPIX_END),
    .VPIX_BEG (VPIX_BEG),
    .VPIX_END (VPIX_END)
  ) u_sync (
    .clk        (clk),
    .arst_n     (arst_n),
    .hint_beg   (hint_beg),
    .vint_beg   (vint_beg),
    .hcnt       (hcnt),
    .vcnt       (vcnt),
    .hsync      (hsync),
    .vsync      (vsync),
    .line_start (line_start),
    .int_start  (int_start),
    .lbuf_raddr (lbuf_raddr),
    .line_odd   (line_odd),
    .win_now    (win_now),
    .in_win     (in_win),
    .sync_blank (sync_blank)
  );

  // clear enable is the raw window, not the delayed one
  video_tsline u_tsline (
    .clk        (clk),
    .line_odd   (line_odd),
    .lbuf_raddr (lbuf_raddr),
    .rd_en      (win_now),
    .ts_waddr   (ts_waddr),
    .ts_wdata   (ts_wdata),
    .ts_we      (ts_we),
    .ts_pix     (ts_pix)
  );

  video_render u_render (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_win      (in_win),
    .sync_blank  (sync_blank),
    .ts_pix      (ts_pix),
    .gfx_pix     (gfx_pix),
    .border      (border),
    .palsel_bank (palsel_bank),
    .nogfx       (nogfx),
    .notsu       (notsu),
    .vplex       (vplex),
    .blank       (blank)
  );

  video_palette u_palette (
    .clk       (clk),
    .arst_n    (arst_n),
    .vplex     (vplex),
    .blank     (blank),
    .cram_addr (cram_addr),
    .cram_data (cram_data),
    .cram_we   (cram_we),
    .red       (red),
    .green     (green),
    .blue      (blue)
  );

endmodule

`default_nettype wire

/* video_palette.sv */
// colour ram palette, 256 entries of 15-bit rgb written by the cpu
// registered lookup of the pixel index with blanking
`timescale 1ns/1ps
`default_nettype none

module video_palette (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire  video_pkg::pix_t     vplex,
  input  wire                       blank,
  input  wire  video_pkg::pix_t     cram_addr,
  input  wire  video_pkg::cram_data_t cram_data,
  input  wire                       cram_we,
  output video_pkg::chan_t          red,
  output video_pkg::chan_t          green,
  output video_pkg::chan_t          blue
);

  import video_pkg::*;

  rgb_t cram [0:255];
  rgb_t colour;

  // cpu side
  // bit 15 of the word is not stored
  always_ff @(posedge clk) begin
    if (cram_we)
      cram[cram_addr] <= cram_data[14:0];
  end

  // lookup sees a write from the cycle after it lands
  assign colour = cram[vplex];

  // output stage, forced black in sync
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      red   <= '0;
      green <= '0;
      blue  <= '0;
    end else if (blank) begin
      red   <= '0;
      green <= '0;
      blue  <= '0;
    end else begin
      red   <= colour[14:10];
      green <= colour[9:5];
      blue  <= colour[4:0];
    end
  end

endmodule

`default_nettype wire

/* video_render.sv */
// pixel mux between border, graphics and overlay
// two register stages, input alignment then the selected index
`timescale 1ns/1ps
`default_nettype none

module video_render (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire                   in_win,
  input  wire                   sync_blank,
  input  wire  video_pkg::pix_t ts_pix,
  input  wire  video_pkg::nib_t gfx_pix,
  input  wire  video_pkg::pix_t border,
  input  wire  video_pkg::nib_t palsel_bank,
  input  wire                   nogfx,
  input  wire                   notsu,
  output video_pkg::pix_t       vplex,
  output logic                  blank
);

  import video_pkg::*;

  // stage 1, sampled with the counters to meet the buffer read
  nib_t gfx_q;
  nib_t bank_q;
  pix_t border_q;
  logic nogfx_q;
  logic notsu_q;

  // pixel data, no reset
  always_ff @(posedge clk) begin
    gfx_q    <= gfx_pix;
    bank_q   <= palsel_bank;
    border_q <= border;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      nogfx_q <= 1'b0;
      notsu_q <= 1'b0;
      vplex   <= '0;
      blank   <= 1'b0;
    end else begin
      nogfx_q <= nogfx;
      notsu_q <= notsu;
      blank   <= sync_blank;
      // stage 2, priority border then overlay then graphics
      if (!in_win)
        vplex <= border_q;
      // low nibble zero is transparent
      else if (!notsu_q && (ts_pix[3:0] != '0))
        vplex <= ts_pix;
      else if (nogfx_q)
        vplex <= border_q;
      else
        vplex <= {bank_q, gfx_q};
    end
  end

endmodule

`default_nettype wire

/* video_tsline.sv */
// two ping-pong overlay line buffers of 512 x 8
// raster side reads and clears one line while the other is filled
`timescale 1ns/1ps
`default_nettype none

module video_tsline (
  input  wire                        clk,
  input  wire                        line_odd,
  input  wire  video_pkg::lbuf_addr_t lbuf_raddr,
  input  wire                        rd_en,
  input  wire  video_pkg::lbuf_addr_t ts_waddr,
  input  wire  video_pkg::pix_t       ts_wdata,
  input  wire                        ts_we,
  output video_pkg::pix_t            ts_pix
);

  import video_pkg::*;

  // buffer index equals line parity on the read side
  pix_t lbuf [0:1][0:511];

  logic rd_sel;
  logic wr_sel;

  // writer fills the buffer of the next line
  assign rd_sel = line_odd;
  assign wr_sel = ~line_odd;

  // the two ports never touch the same buffer
  always_ff @(posedge clk) begin
    // outside write port into the idle buffer
    if (ts_we)
      lbuf[wr_sel][ts_waddr] <= ts_wdata;
    // read port of the active buffer
    // old contents come out and the cell is zeroed on the same edge
    ts_pix <= lbuf[rd_sel][lbuf_raddr];
    // only window pixels are cleared so each is shown once
    if (rd_en)
      lbuf[rd_sel][lbuf_raddr] <= '0;
  end

endmodule

`default_nettype wire

/* video_sync.sv */
// raster counters with registered syncs, line start and frame interrupt
// also window flags and overlay buffer read address for the pixel path
`timescale 1ns/1ps
`default_nettype none

module video_sync #(
  parameter int H_TOTAL  = 448,
  parameter int V_TOTAL  = 320,
  parameter int HPIX_BEG = 64,
  parameter int HPIX_END = 320,
  parameter int VPIX_BEG = 40,
  parameter int VPIX_END = 232
) (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire  video_pkg::pix_t   hint_beg,
  input  wire  video_pkg::vcnt_t  vint_beg,
  output video_pkg::hcnt_t        hcnt,
  output video_pkg::vcnt_t        vcnt,
  output logic                    hsync,
  output logic                    vsync,
  output logic                    line_start,
  output logic                    int_start,
  output video_pkg::lbuf_addr_t   lbuf_raddr,
  output logic                    line_odd,
  output logic                    win_now,
  output logic                    in_win,
  output logic                    sync_blank
);

  import video_pkg::*;

  logic h_last;
  logic v_last;

  assign h_last = (hcnt == hcnt_t'(H_TOTAL - 1));
  assign v_last = (vcnt == vcnt_t'(V_TOTAL - 1));

  // pixel and line counters
  // vcnt steps when hcnt wraps
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (h_last) begin
      hcnt <= '0;
      vcnt <= v_last ? '0 : vcnt + 1'b1;
    end else begin
      hcnt <= hcnt + 1'b1;
    end
  end

  // raw window term, drives the overlay clear
  assign win_now = (hcnt >= hcnt_t'(HPIX_BEG)) && (hcnt < hcnt_t'(HPIX_END)) &&
                   (vcnt >= vcnt_t'(VPIX_BEG)) && (vcnt < vcnt_t'(VPIX_END));

  // overlay x is relative to the window start
  assign lbuf_raddr = lbuf_addr_t'(hcnt - hcnt_t'(HPIX_BEG));

  // even lines read buffer 0
  assign line_odd = vcnt[0];

  // decoded outputs, one cycle behind the counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hsync      <= 1'b0;
      vsync      <= 1'b0;
      line_start <= 1'b0;
      int_start  <= 1'b0;
      in_win     <= 1'b0;
    end else begin
      hsync      <= (hcnt < hcnt_t'(HSYNC_LEN));
      vsync      <= (vcnt < vcnt_t'(VSYNC_LEN));
      line_start <= (hcnt == '0);
      // one pulse per frame at the programmed point
      int_start  <= (hcnt == hcnt_t'(hint_beg)) && (vcnt == vint_beg);
      // aligned with the buffer read data
      in_win     <= win_now;
    end
  end

  // syncs are already one cycle late, same stage as in_win
  assign sync_blank = hsync | vsync;

endmodule

`default_nettype wire

/* video_ports.sv */
// configuration registers loaded from the cpu data bus by port write strobes
// each register takes d on the cycle after its strobe
`timescale 1ns/1ps
`default_nettype none

module video_ports (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire  video_pkg::pix_t d,
  input  wire                   border_wr,
  input  wire                   vconf_wr,
  input  wire                   palsel_wr,
  input  wire                   hint_beg_wr,
  input  wire                   vint_begl_wr,
  input  wire                   vint_begh_wr,
  output video_pkg::pix_t       border,
  output logic                  nogfx,
  output logic                  notsu,
  output video_pkg::nib_t       palsel_bank,
  output video_pkg::pix_t       hint_beg,
  output video_pkg::vcnt_t      vint_beg
);

  import video_pkg::*;

  // border colour index
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      border <= '0;
    end else if (border_wr) begin
      border <= d;
    end
  end

  // vconf, only the two layer enables are kept
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      nogfx <= 1'b0;
      notsu <= 1'b0;
    end else if (vconf_wr) begin
      nogfx <= d[VCONF_NOGFX];
      notsu <= d[VCONF_NOTSU];
    end
  end

  // palsel, graphics bank in the low nibble
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      palsel_bank <= '0;
    end else if (palsel_wr) begin
      palsel_bank <= d[3:0];
    end
  end

  // interrupt point, line split over two ports
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hint_beg <= '0;
      vint_beg <= '0;
    end else begin
      if (hint_beg_wr)
        hint_beg <= d;
      // low byte of the line number
      if (vint_begl_wr)
        vint_beg[7:0] <= d;
      // line bit 8 comes from d[0]
      if (vint_begh_wr)
        vint_beg[8] <= d[0];
    end
  end

endmodule

`default_nettype wire

/* video_pkg.sv */
// shared widths, pixel types and sync constants for the video pipeline
// modules import this inside their bodies and name its types in their ports
`default_nettype none

package video_pkg;

  // raster position, one pixel per clk
  typedef logic [8:0] hcnt_t;
  typedef logic [8:0] vcnt_t;

  // palette index, also the overlay pixel format
  typedef logic [7:0] pix_t;

  // graphics nibble or palette bank
  typedef logic [3:0] nib_t;

  // overlay line buffer address, 512 pixels per line
  typedef logic [8:0] lbuf_addr_t;

  // colour word as written by the cpu, bit 15 ignored
  typedef logic [15:0] cram_data_t;

  // stored colour, red 14..10 green 9..5 blue 4..0
  typedef logic [14:0] rgb_t;

  // single colour channel
  typedef logic [4:0] chan_t;

  // hsync width in pixels
  localparam int HSYNC_LEN = 4;

  // vsync height in lines
  localparam int VSYNC_LEN = 2;

  // vconf bit positions
  // graphics off, border shown in the window
  localparam int VCONF_NOGFX = 5;
  // overlay off
  localparam int VCONF_NOTSU = 4;

endpackage

`default_nettype wire
